//--- design/cache_pkg.sv
// Shared definitions for the L1 data cache
// Geometry, bus tags, access kinds and the cache line views
package cache_pkg;

  parameter int ADDR_W = 32;
  parameter int OFFSET_W = 6;    // 64 byte lines
  parameter int INDEX_W = 5;     // 32 sets
  parameter int TAG_W = 21;
  parameter int BEATS = 8;       // 64-bit beats per line
  parameter int DEFAULT_WAYS = 4;

  typedef logic [63:0] mem_word_t;

  // Tag carried on both bus directions
  typedef enum logic [1:0] {
    MEM_NONE = 2'd0,
    MEM_READ = 2'd1,
    MEM_WRITE = 2'd2
  } bus_tag_t;

  // Loads, the U forms zero-extend
  typedef enum logic [2:0] {
    LD,
    LW,
    LH,
    LB,
    LWU,
    LHU,
    LBU
  } load_kind_t;

  typedef enum logic [1:0] {
    SD,
    SW,
    SH,
    SB
  } store_kind_t;

  // One line seen at four access sizes, element 0 at byte offset 0
  typedef union packed {
    logic [BEATS-1:0][63:0] dwords;
    logic [15:0][31:0] words;
    logic [31:0][15:0] halves;
    logic [63:0][7:0] bytes;
  } cache_line_t;

endpackage

//--- design/beat_counter.sv
// Beat counter for line transfers on the memory bus
`timescale 1ns/1ps

module beat_counter (
  input  logic clk,
  input  logic reset,
  input  logic clear,
  input  logic en,
  output logic last
);
  import cache_pkg::*;

  logic [$clog2(BEATS)-1:0] count;

  always_ff @(posedge clk) begin
    if (!reset)
      count <= '0;
    else if (clear)
      count <= '0;
    else if (en)
      count <= count + 1'b1;
  end

  assign last = en && (count == BEATS - 1); // Eighth beat in progress

endmodule

//--- design/cache_array.sv
// Tag, state and data storage for the data cache
// Registered set read, hit compare and victim choice
`timescale 1ns/1ps

module cache_array #(
  parameter int NUM_WAYS = cache_pkg::DEFAULT_WAYS
) (
  input  logic clk,
  input  logic reset,
  input  logic lookup_en,
  input  logic [cache_pkg::ADDR_W-1:0] addr,
  input  logic fill_we,
  input  cache_pkg::cache_line_t fill_line,
  input  logic store_we,
  input  cache_pkg::cache_line_t store_line,
  output logic hit,
  output cache_pkg::cache_line_t hit_line,
  output logic victim_dirty,
  output logic [cache_pkg::ADDR_W-1:0] victim_addr,
  output cache_pkg::cache_line_t victim_line
);
  import cache_pkg::*;

  localparam int SETS = 1 << INDEX_W;
  localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  logic [TAG_W-1:0] tags [NUM_WAYS][SETS];
  cache_line_t lines [NUM_WAYS][SETS];
  logic [NUM_WAYS-1:0][SETS-1:0] valid, dirty;

  logic [INDEX_W-1:0] index;
  logic [TAG_W-1:0] rd_tag [NUM_WAYS];
  cache_line_t rd_line [NUM_WAYS];
  logic [NUM_WAYS-1:0] rd_valid, rd_dirty;
  logic [TAG_W-1:0] req_tag;
  logic [INDEX_W-1:0] req_index;
  logic [WAY_W-1:0] hit_way, victim_way, rr_ptr;

  assign index = addr[OFFSET_W +: INDEX_W];

  always_ff @(posedge clk) begin
    if (lookup_en) begin
      req_tag <= addr[ADDR_W-1 -: TAG_W];
      req_index <= index;
      for (int w = 0; w < NUM_WAYS; w++) begin
        rd_tag[w] <= tags[w][index];
        rd_line[w] <= lines[w][index];
        rd_valid[w] <= valid[w][index];
        rd_dirty[w] <= dirty[w][index];
      end
    end
  end

  // Lowest invalid way, else the round-robin way
  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    victim_way = rr_ptr;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (rd_valid[w] && rd_tag[w] == req_tag) begin
        hit = 1'b1;
        hit_way = WAY_W'(w);
      end
      if (!rd_valid[w])
        victim_way = WAY_W'(w);
    end
  end

  assign hit_line = rd_line[hit_way];
  assign victim_line = rd_line[victim_way];
  assign victim_dirty = rd_valid[victim_way] && rd_dirty[victim_way];
  assign victim_addr = {rd_tag[victim_way], req_index, {OFFSET_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (fill_we) begin
      tags[victim_way][req_index] <= req_tag;
      lines[victim_way][req_index] <= fill_line;
    end else if (store_we) begin
      lines[hit_way][req_index] <= store_line;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      valid <= '0;
      dirty <= '0;
      rr_ptr <= '0;
    end else if (fill_we) begin
      valid[victim_way][req_index] <= 1'b1;
      dirty[victim_way][req_index] <= 1'b0;   // Fresh line is clean
      rr_ptr <= (rr_ptr == WAY_W'(NUM_WAYS - 1)) ? '0 : rr_ptr + 1'b1;
    end else if (store_we) begin
      dirty[hit_way][req_index] <= 1'b1;
    end
  end

endmodule

//--- design/line_buffer.sv
// Line buffer between the bus and the array
// Collects fill beats and shifts a victim line out beat by beat
`timescale 1ns/1ps

module line_buffer (
  input  logic clk,
  input  logic capture,
  input  logic load,
  input  logic shift,
  input  cache_pkg::mem_word_t resp_beat,
  input  cache_pkg::cache_line_t victim_line,
  output cache_pkg::cache_line_t line,
  output cache_pkg::mem_word_t out_beat
);
  import cache_pkg::*;

  cache_line_t buf_q;

  always_ff @(posedge clk) begin
    if (load)
      buf_q <= victim_line;
    else if (capture)
      buf_q <= {resp_beat, buf_q.dwords[BEATS-1:1]}; // New beat enters at the top
    else if (shift)
      buf_q <= {64'h0, buf_q.dwords[BEATS-1:1]};
  end

  assign line = buf_q;
  assign out_beat = buf_q.dwords[0]; // Next beat to send

endmodule

//--- design/load_extract.sv
// Load data path
// Picks the addressed item from a line and extends it to 64 bits
`timescale 1ns/1ps

module load_extract (
  input  cache_pkg::cache_line_t line,
  input  logic [cache_pkg::OFFSET_W-1:0] offset,
  input  cache_pkg::load_kind_t kind,
  output cache_pkg::mem_word_t value
);
  import cache_pkg::*;

  logic [63:0] dword_sel;
  logic [31:0] word_sel;
  logic [15:0] half_sel;
  logic [7:0] byte_sel;

  assign dword_sel = line.dwords[offset[OFFSET_W-1:3]];
  assign word_sel = line.words[offset[OFFSET_W-1:2]];
  assign half_sel = line.halves[offset[OFFSET_W-1:1]];
  assign byte_sel = line.bytes[offset];

  always_comb begin
    case (kind)
      LW: value = {{32{word_sel[31]}}, word_sel};
      LH: value = {{48{half_sel[15]}}, half_sel};
      LB: value = {{56{byte_sel[7]}}, byte_sel};
      LWU: value = {32'h0, word_sel};
      LHU: value = {48'h0, half_sel};
      LBU: value = {56'h0, byte_sel};
      default: value = dword_sel; // LD
    endcase
  end

endmodule

//--- design/store_merge.sv
// Store data path
// Writes the low bits of the store data into the line at its offset
`timescale 1ns/1ps

module store_merge (
  input  cache_pkg::cache_line_t line,
  input  logic [cache_pkg::OFFSET_W-1:0] offset,
  input  cache_pkg::store_kind_t kind,
  input  cache_pkg::mem_word_t data,
  output cache_pkg::cache_line_t merged
);
  import cache_pkg::*;

  always_comb begin
    merged = line; // Other bytes pass through
    case (kind)
      SD: merged.dwords[offset[OFFSET_W-1:3]] = data;
      SW: merged.words[offset[OFFSET_W-1:2]] = data[31:0];
      SH: merged.halves[offset[OFFSET_W-1:1]] = data[15:0];
      default: merged.bytes[offset] = data[7:0]; // SB
    endcase
  end

endmodule

//--- design/cache_ctrl.sv
// Cache controller FSM
// Sequences lookup, write-back, fill and refill, and raises the done pulses
`timescale 1ns/1ps

module cache_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic mem_read,
  input  logic mem_write,
  input  logic hit,
  input  logic victim_dirty,
  input  logic beat_last,
  input  logic bus_reqack,
  input  logic bus_respcyc,
  input  cache_pkg::bus_tag_t bus_resptag,
  output logic use_write,
  output logic lookup_en,
  output logic fill_we,
  output logic store_we,
  output logic beat_en,
  output logic beat_clear,
  output logic buf_capture,
  output logic buf_load,
  output logic buf_shift,
  output logic bus_reqcyc,
  output cache_pkg::bus_tag_t bus_reqtag,
  output logic req_is_wb,
  output logic bus_respack,
  output logic read_done,
  output logic write_done
);
  import cache_pkg::*;

  typedef enum logic [2:0] {
    IDLE, LOOKUP, WB_REQ, WB_DATA, WB_WAIT, FILL_REQ, FILL_DATA, REFILL
  } state_t;

  state_t state, state_next;
  logic tags_valid;          // Array output belongs to this lookup
  logic resp_read, resp_write;

  assign resp_read = bus_respcyc && (bus_resptag == MEM_READ);
  assign resp_write = bus_respcyc && (bus_resptag == MEM_WRITE);

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= IDLE;
      tags_valid <= 1'b0;
      use_write <= 1'b0;
    end else begin
      state <= state_next;
      tags_valid <= (state == LOOKUP) && !tags_valid;
      if (state == IDLE)
        use_write <= mem_write; // Latched for the whole request
    end
  end

  always_comb begin
    state_next = state;
    lookup_en = 1'b0;
    fill_we = 1'b0;
    store_we = 1'b0;
    beat_en = 1'b0;
    beat_clear = 1'b0;
    buf_capture = 1'b0;
    buf_load = 1'b0;
    buf_shift = 1'b0;
    bus_reqcyc = 1'b0;
    bus_reqtag = MEM_NONE;
    req_is_wb = 1'b0;
    bus_respack = 1'b0;
    read_done = 1'b0;
    write_done = 1'b0;
    case (state)
      IDLE: if (mem_read || mem_write) state_next = LOOKUP;
      LOOKUP: begin
        if (!tags_valid) begin
          lookup_en = 1'b1;   // Set read, result next cycle
        end else if (hit) begin
          store_we = use_write;
          write_done = use_write;
          read_done = !use_write;
          state_next = IDLE;
        end else if (victim_dirty) begin
          buf_load = 1'b1;
          state_next = WB_REQ;
        end else begin
          state_next = FILL_REQ;
        end
      end
      WB_REQ: begin
        bus_reqcyc = 1'b1;
        bus_reqtag = MEM_WRITE;
        req_is_wb = 1'b1;
        beat_clear = 1'b1;
        if (bus_reqack) state_next = WB_DATA;
      end
      WB_DATA: begin          // One beat per cycle, no gaps
        bus_reqcyc = 1'b1;
        bus_reqtag = MEM_WRITE;
        buf_shift = 1'b1;
        beat_en = 1'b1;
        if (beat_last) state_next = WB_WAIT;
      end
      WB_WAIT: begin
        bus_respack = resp_write;
        if (resp_write) state_next = FILL_REQ;
      end
      FILL_REQ: begin
        bus_reqcyc = 1'b1;
        bus_reqtag = MEM_READ;
        beat_clear = 1'b1;
        if (bus_reqack) state_next = FILL_DATA;
      end
      FILL_DATA: begin
        bus_respack = resp_read;
        buf_capture = resp_read;
        beat_en = resp_read;
        if (beat_last) state_next = REFILL;
      end
      REFILL: begin
        fill_we = 1'b1;
        state_next = LOOKUP;  // Re-read the set, then hit
      end
      default: state_next = IDLE;
    endcase
  end

endmodule

//--- design/l1d_cache.sv
// L1 data cache, 8 KB, 4-way, 64 byte lines
// One load and one store port, write-back over the tagged memory bus
`timescale 1ns/1ps

module l1d_cache #(
  parameter int NUM_WAYS = cache_pkg::DEFAULT_WAYS
) (
  input  logic clk,
  input  logic reset,
  input  logic mem_read,
  input  logic [cache_pkg::ADDR_W-1:0] read_address,
  input  cache_pkg::load_kind_t read_type,
  input  cache_pkg::store_kind_t write_type,
  output cache_pkg::mem_word_t read_data,
  output logic read_done,
  input  logic mem_write,
  input  logic [cache_pkg::ADDR_W-1:0] write_address,
  input  cache_pkg::mem_word_t write_data,
  output logic write_done,
  output logic bus_reqcyc,
  output cache_pkg::mem_word_t bus_req,
  output cache_pkg::bus_tag_t bus_reqtag,
  input  logic bus_reqack,
  input  logic bus_respcyc,
  input  cache_pkg::mem_word_t bus_resp,
  input  cache_pkg::bus_tag_t bus_resptag,
  output logic bus_respack
);
  import cache_pkg::*;

  logic use_write, lookup_en, fill_we, store_we;
  logic beat_en, beat_clear, beat_last;
  logic buf_capture, buf_load, buf_shift, req_is_wb;
  logic hit, victim_dirty;
  logic [ADDR_W-1:0] req_addr, fill_addr, victim_addr, bus_addr;
  cache_line_t hit_line, victim_line, fill_line, store_line;
  mem_word_t out_beat;

  assign req_addr = use_write ? write_address : read_address; // Store wins
  assign fill_addr = {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign bus_addr = req_is_wb ? victim_addr : fill_addr;
  assign bus_req = buf_shift ? out_beat : {{(64 - ADDR_W){1'b0}}, bus_addr};

  cache_ctrl u_ctrl (
    .clk(clk), .reset(reset),
    .mem_read(mem_read), .mem_write(mem_write),
    .hit(hit), .victim_dirty(victim_dirty), .beat_last(beat_last),
    .bus_reqack(bus_reqack), .bus_respcyc(bus_respcyc), .bus_resptag(bus_resptag),
    .use_write(use_write), .lookup_en(lookup_en),
    .fill_we(fill_we), .store_we(store_we),
    .beat_en(beat_en), .beat_clear(beat_clear),
    .buf_capture(buf_capture), .buf_load(buf_load), .buf_shift(buf_shift),
    .bus_reqcyc(bus_reqcyc), .bus_reqtag(bus_reqtag), .req_is_wb(req_is_wb),
    .bus_respack(bus_respack), .read_done(read_done), .write_done(write_done)
  );

  beat_counter u_beats (
    .clk(clk), .reset(reset), .clear(beat_clear), .en(beat_en), .last(beat_last)
  );

  cache_array #(.NUM_WAYS(NUM_WAYS)) u_array (
    .clk(clk), .reset(reset), .lookup_en(lookup_en), .addr(req_addr),
    .fill_we(fill_we), .fill_line(fill_line),
    .store_we(store_we), .store_line(store_line),
    .hit(hit), .hit_line(hit_line), .victim_dirty(victim_dirty),
    .victim_addr(victim_addr), .victim_line(victim_line)
  );

  line_buffer u_buf (
    .clk(clk), .capture(buf_capture), .load(buf_load), .shift(buf_shift),
    .resp_beat(bus_resp), .victim_line(victim_line),
    .line(fill_line), .out_beat(out_beat)
  );

  load_extract u_load (
    .line(hit_line), .offset(req_addr[OFFSET_W-1:0]), .kind(read_type), .value(read_data)
  );

  store_merge u_store (
    .line(hit_line), .offset(req_addr[OFFSET_W-1:0]), .kind(write_type),
    .data(write_data), .merged(store_line)
  );

endmodule

//--- verif/l1d_cache_tb.sv
// Testbench for the L1 data cache
// Bus memory model with random delays, byte reference map and directed tests
`timescale 1ns/1ps

module l1d_cache_tb;
  import cache_pkg::*;

  localparam int MAX_CYCLES = 20000;               // Tests need under about 4000
  localparam int HIT_WAIT = 3;                     // Negedges from drive to done on a hit
  localparam logic [31:0] LINE_A = 32'h0003_4040;  // Set 1
  localparam logic [31:0] LINE_B = 32'h0010_0140;  // Set 5
  localparam logic [31:0] LINE_C = 32'h0020_0240;  // Set 9
  localparam logic [31:0] LINE_D = 32'h0030_0300;  // Set 12
  localparam logic [31:0] SET_STRIDE = 32'h800;    // Same set, next tag

  logic clk;
  logic reset;
  logic mem_read;
  logic [31:0] read_address;
  load_kind_t read_type;
  store_kind_t write_type;
  mem_word_t read_data;
  logic read_done;
  logic mem_write;
  logic [31:0] write_address;
  mem_word_t write_data;
  logic write_done;
  logic bus_reqcyc;
  mem_word_t bus_req;
  bus_tag_t bus_reqtag;
  logic bus_reqack;
  logic bus_respcyc;
  mem_word_t bus_resp;
  bus_tag_t bus_resptag;
  logic bus_respack;

  logic [31:0] lfsr = 32'haf1b;
  int cycles = 0;
  int req_count = 0;
  int wb_count = 0;
  logic [31:0] first_req_addr;
  bus_tag_t first_req_tag;
  mem_word_t mem_dw [logic [31:0]];        // Backing memory by dword address
  logic [7:0] ref_bytes [logic [31:0]];    // Expected contents, every store applied
  bit stored_lines [logic [31:0]];

  l1d_cache uut (
    .clk(clk), .reset(reset),
    .mem_read(mem_read), .read_address(read_address), .read_type(read_type),
    .write_type(write_type), .read_data(read_data), .read_done(read_done),
    .mem_write(mem_write), .write_address(write_address), .write_data(write_data),
    .write_done(write_done),
    .bus_reqcyc(bus_reqcyc), .bus_req(bus_req), .bus_reqtag(bus_reqtag),
    .bus_reqack(bus_reqack), .bus_respcyc(bus_respcyc), .bus_resp(bus_resp),
    .bus_resptag(bus_resptag), .bus_respack(bus_respack)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES)
      fail_run($sformatf("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES));
  end

  task automatic fail_run(string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check_word(mem_word_t got, mem_word_t exp, string what);
    if (got !== exp)
      fail_run($sformatf("** Error at %0t: %s, got %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_tag(bus_tag_t got, bus_tag_t exp, string what);
    if (got !== exp)
      fail_run($sformatf("** Error at %0t: %s, got %s, expected %s", $time, what,
                         got.name(), exp.name()));
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp)
      fail_run($sformatf("** Error at %0t: %s, got %b, expected %b", $time, what, got, exp));
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic mem_word_t rand_bits(int n);
    mem_word_t v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic int load_size(load_kind_t kind);
    case (kind)
      LD: return 8;
      LW, LWU: return 4;
      LH, LHU: return 2;
      default: return 1;
    endcase
  endfunction

  // Little-endian load from the reference map, extended by kind
  function automatic mem_word_t expect_load(logic [31:0] addr, load_kind_t kind);
    int n;
    logic [31:0] base;
    mem_word_t v;
    n = load_size(kind);
    base = addr & ~32'(n - 1);
    v = '0;
    for (int i = n - 1; i >= 0; i--)
      v = (v << 8) | mem_word_t'(ref_bytes[base + 32'(i)]);
    if ((kind == LW || kind == LH || kind == LB) && v[8*n-1])
      v = v | ~((64'h1 << (8 * n)) - 64'h1);
    return v;
  endfunction

  function automatic void store_ref(logic [31:0] addr, store_kind_t kind, mem_word_t data);
    int n;
    logic [31:0] base;
    n = 8 >> kind;   // SD, SW, SH, SB
    base = addr & ~32'(n - 1);
    for (int i = 0; i < n; i++)
      ref_bytes[base + 32'(i)] = data[8*i +: 8];
    stored_lines[{addr[31:6], 6'd0}] = 1'b1;
  endfunction

  task automatic wait_respack();
    do @(negedge clk); while (!bus_respack);
    @(posedge clk);
    #1;
  endtask

  task automatic send_fill(logic [31:0] line_addr);
    mem_word_t w;
    int gap;
    if (!mem_dw.exists(line_addr)) begin   // First touch creates the line
      for (int i = 0; i < BEATS; i++) begin
        w = rand_bits(64);
        mem_dw[line_addr + 32'(8 * i)] = w;
        for (int b = 0; b < 8; b++)
          ref_bytes[line_addr + 32'(8 * i + b)] = w[8*b +: 8];
      end
    end
    for (int i = 0; i < BEATS; i++) begin
      gap = int'(rand_bits(2));
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      bus_respcyc = 1'b1;
      bus_resptag = MEM_READ;
      bus_resp = mem_dw[line_addr + 32'(8 * i)];
      wait_respack();
      bus_respcyc = 1'b0;
      bus_resptag = MEM_NONE;
    end
  endtask

  task automatic take_write_back(logic [31:0] line_addr);
    int gap;
    wb_count++;
    check_bit(stored_lines.exists(line_addr) != 0, 1'b1, "write-back of a line never stored");
    for (int i = 0; i < BEATS; i++) begin   // Beats come in back-to-back cycles
      @(negedge clk);
      check_bit(bus_reqcyc, 1'b1, "bus_reqcyc during write-back beats");
      check_tag(bus_reqtag, MEM_WRITE, "tag during write-back beats");
      check_word(bus_req, expect_load(line_addr + 32'(8 * i), LD), "write-back beat");
      mem_dw[line_addr + 32'(8 * i)] = bus_req;
    end
    @(posedge clk);
    #1;
    gap = int'(rand_bits(2));
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    bus_respcyc = 1'b1;
    bus_resptag = MEM_WRITE;
    wait_respack();
    bus_respcyc = 1'b0;
    bus_resptag = MEM_NONE;
  endtask

  // Memory side of the bus
  initial begin : memory_model
    logic [31:0] line_addr;
    bus_tag_t tag;
    int delay;
    forever begin
      @(negedge clk);
      if (reset && bus_reqcyc) begin
        line_addr = bus_req[31:0];
        tag = bus_reqtag;
        if (req_count == 0) begin
          first_req_addr = line_addr;
          first_req_tag = tag;
        end
        req_count++;
        check_bit(line_addr[5:0] == 6'd0, 1'b1, "bus request address is line aligned");
        delay = int'(rand_bits(2));
        repeat (delay + 1) @(posedge clk);
        #1 bus_reqack = 1'b1;
        @(posedge clk);
        #1 bus_reqack = 1'b0;
        if (tag == MEM_WRITE)
          take_write_back(line_addr);
        else
          send_fill(line_addr);
      end
    end
  end

  task automatic do_load(input logic [31:0] addr, input load_kind_t kind,
                         output mem_word_t value, output int waited);
    mem_read = 1'b1;
    read_address = addr;
    read_type = kind;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!read_done);
    value = read_data;
    @(posedge clk);
    #1 mem_read = 1'b0;
  endtask

  task automatic do_store(logic [31:0] addr, store_kind_t kind, mem_word_t data);
    mem_write = 1'b1;
    write_address = addr;
    write_type = kind;
    write_data = data;
    do @(negedge clk); while (!write_done);
    store_ref(addr, kind, data);
    @(posedge clk);
    #1 mem_write = 1'b0;
  endtask

  task automatic load_and_check(logic [31:0] addr, load_kind_t kind, string what);
    mem_word_t value;
    int waited;
    do_load(addr, kind, value, waited);
    check_word(value, expect_load(addr, kind), what);
  endtask

  task automatic test_reset_and_first_miss();
    @(negedge clk);
    check_bit(bus_reqcyc, 1'b0, "bus_reqcyc after reset");
    check_bit(bus_respack, 1'b0, "bus_respack after reset");
    check_bit(read_done, 1'b0, "read_done after reset");
    check_bit(write_done, 1'b0, "write_done after reset");
    @(posedge clk);
    #1;
    load_and_check(LINE_A + 32'h18, LD, "first load");
    check_tag(first_req_tag, MEM_READ, "first bus request tag");
    check_word({32'h0, first_req_addr}, {32'h0, LINE_A}, "first bus request address");
  endtask

  task automatic test_load_kinds();
    load_kind_t kind;
    logic [31:0] addr;
    mem_word_t value;
    int waited;
    for (int i = 0; i < 21; i++) begin
      kind = load_kind_t'(3'(i % 7));
      addr = LINE_A | (32'(rand_bits(6)) & ~32'(load_size(kind) - 1));
      do_load(addr, kind, value, waited);
      check_word(value, expect_load(addr, kind), "load kind on a filled line");
      check_bit(waited == HIT_WAIT, 1'b1, "hit latency");
    end
  endtask

  task automatic test_stores();
    store_kind_t kind;
    logic [31:0] addr;
    logic [31:0] dw_addr;
    for (int i = 0; i < 8; i++) begin
      kind = store_kind_t'(2'(i % 4));
      addr = LINE_A | (32'(rand_bits(6)) & ~32'((8 >> kind) - 1));
      do_store(addr, kind, rand_bits(64));
      dw_addr = addr & ~32'h7;
      load_and_check(dw_addr, LD, "dword holding the store");
      dw_addr = LINE_A | ((dw_addr + 32'h8) & 32'h3f);
      load_and_check(dw_addr, LD, "dword next to the store");
    end
  endtask

  task automatic test_dirty_eviction();
    int wb_before;
    wb_before = wb_count;
    for (int k = 0; k < 5; k++)
      do_store(LINE_B + 32'(k) * SET_STRIDE + 32'h10, SD, rand_bits(64));
    for (int k = 0; k < 5; k++)
      load_and_check(LINE_B + 32'(k) * SET_STRIDE + 32'h10, LD, "load after dirty eviction");
    check_bit(wb_count > wb_before, 1'b1, "dirty eviction produced a write-back");
  endtask

  task automatic test_clean_eviction();
    int wb_before;
    wb_before = wb_count;
    for (int pass = 0; pass < 2; pass++) begin
      for (int k = 0; k < 5; k++)
        load_and_check(LINE_C + 32'(k) * SET_STRIDE + 32'h28, LW, "load in a clean set");
    end
    check_bit(wb_count == wb_before, 1'b1, "no write-back for clean lines");
  endtask

  task automatic test_load_store_together();
    mem_word_t data;
    mem_word_t value;
    data = rand_bits(64);
    mem_read = 1'b1;
    read_address = LINE_D + 32'h20;
    read_type = LD;
    mem_write = 1'b1;
    write_address = LINE_D + 32'h20;
    write_type = SD;
    write_data = data;
    do begin
      @(negedge clk);
      check_bit(read_done, 1'b0, "read_done ahead of write_done");
    end while (!write_done);
    store_ref(LINE_D + 32'h20, SD, data);
    @(posedge clk);
    #1 mem_write = 1'b0;
    do @(negedge clk); while (!read_done);
    value = read_data;
    @(posedge clk);
    #1 mem_read = 1'b0;
    check_word(value, expect_load(LINE_D + 32'h20, LD), "load held with a store");
  endtask

  initial begin
    reset = 1'b0;
    mem_read = 1'b0;
    read_address = '0;
    read_type = LD;
    write_type = SD;
    mem_write = 1'b0;
    write_address = '0;
    write_data = '0;
    bus_reqack = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp = '0;
    bus_resptag = MEM_NONE;
    repeat (10) @(posedge clk);
    #1 reset = 1'b1;
    test_reset_and_first_miss();
    test_load_kinds();
    test_stores();
    test_dirty_eviction();
    test_clean_eviction();
    test_load_store_together();
    $display("Regression passed");
    $finish;
  end

endmodule

//--- sim.f
design/cache_pkg.sv
design/beat_counter.sv
design/cache_array.sv
design/line_buffer.sv
design/load_extract.sv
design/store_merge.sv
design/cache_ctrl.sv
design/l1d_cache.sv
verif/l1d_cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it, exit status carries pass or fail
verilator --binary --timing -Wno-fatal --top-module l1d_cache_tb -f sim.f -o l1d_cache_sim \
  && ./obj_dir/l1d_cache_sim \
  || exit 1
